// ==== common/memSysPkg.sv ====
package memSysPkg;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_ACCESS_RAS,
		ST_ACCESS_HOLD,
		ST_CYCLE_END,
		ST_REF_RAS1,
		ST_REF_RAS2,
		ST_PRECHARGE,
		ST_REENABLE
	} ramStateT;

	typedef enum logic [1:0] {REGION_NONE, REGION_RAM, REGION_ROM} regionT;

	// Compared against A23..A20, RAM and ROM split on A23:A22 only
	localparam logic [3:0] RAM_TOP_NIBBLE = 4'h0; // 0x000000, also the low region
	localparam logic [3:0] ROM_TOP_NIBBLE = 4'h4; // 0x400000

	// DRAM pin map, ramAddr[11] down to ramAddr[0]
	//   row:    A19 A17 A15 A18 A14 A13 A12 A11 A19 A16 A10 A9
	//   column: A20 A7  A8  A21 A6  A5  A4  A3  A20 A7  A2  A1
	// Pins 11 and 3 carry the same bit, pin 10 has no column role
	// Flash sees A18 on pin 8 and A19 on pin 11 through the row mux

endpackage

// ==== common/cpuBusIf.sv ====
`timescale 1ns/1ps

interface cpuBusIf;

	logic [22:0] address; // A23 down to A1
	logic nAs;
	logic nWe; // Low for a write
	logic nLds;
	logic nUds;
	logic nDtack; // Returned by the DTACK generator

	modport decode (
		input address,
		input nAs
	);

	modport ram (
		input address,
		input nAs,
		input nWe,
		input nLds,
		input nUds,
		input nDtack
	);

	modport dtack (input nAs);

endinterface

// ==== hdl/addrDecode.sv ====
`timescale 1ns/1ps

module addrDecode (
	input logic CLK,
	input logic rstN,
	cpuBusIf.decode bus,
	input logic romAccess,
	output logic busActive,
	output logic ramSel,
	output logic romSel,
	output logic lowRegionSel
);
	import memSysPkg::*;

	logic [3:0] topNibble;
	logic overlay;
	regionT region;
	regionT decoded;

	assign topNibble = bus.address[22:19];

	always_comb begin
		if (overlay && topNibble == RAM_TOP_NIBBLE) begin
			decoded = REGION_ROM; // Boot vectors come from flash
		end else if (topNibble[3:2] == RAM_TOP_NIBBLE[3:2]) begin
			decoded = REGION_RAM;
		end else if (topNibble[3:2] == ROM_TOP_NIBBLE[3:2]) begin
			decoded = REGION_ROM;
		end else begin
			decoded = REGION_NONE;
		end
	end

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			busActive <= 1'b0;
			overlay <= 1'b1;
			region <= REGION_NONE;
			lowRegionSel <= 1'b0;
		end else begin
			busActive <= !bus.nAs;
			if (romAccess)
				overlay <= 1'b0; // First ROM DTACK ends boot mode
			if (bus.nAs) begin
				region <= REGION_NONE;
				lowRegionSel <= 1'b0;
			end else if (!busActive) begin // Latch once per AS cycle
				region <= decoded;
				lowRegionSel <= (topNibble == RAM_TOP_NIBBLE);
			end
		end
	end

	assign ramSel = (region == REGION_RAM);
	assign romSel = (region == REGION_ROM);

endmodule

// ==== hdl/refreshTimer.sv ====
`timescale 1ns/1ps

module refreshTimer #(
	parameter int REFRESH_PERIOD = 120,
	parameter int URGENT_DELAY = 40
) (
	input logic CLK,
	input logic rstN,
	input logic refAck,
	output logic refReq,
	output logic refUrg
);

	localparam int PERIOD_W = $clog2(REFRESH_PERIOD);
	localparam int URG_W = $clog2(URGENT_DELAY + 1);

	logic [PERIOD_W-1:0] periodCnt;
	logic [URG_W-1:0] urgCnt;
	logic periodDone;

	assign periodDone = (periodCnt == PERIOD_W'(REFRESH_PERIOD - 1));

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			periodCnt <= '0;
			urgCnt <= '0;
			refReq <= 1'b0;
			refUrg <= 1'b0;
		end else begin
			periodCnt <= periodDone ? '0 : periodCnt + 1'b1; // Free running
			refReq <= (refReq && !refAck) || periodDone;
			if (refAck || !refReq) begin
				urgCnt <= '0;
				refUrg <= 1'b0;
			end else if (urgCnt == URG_W'(URGENT_DELAY - 1)) begin
				refUrg <= 1'b1; // Request went unserved too long
			end else begin
				urgCnt <= urgCnt + 1'b1;
			end
		end
	end

	urgImpliesReq: assert property (@(posedge CLK) disable iff (!rstN) refUrg |-> refReq)
		else $error("refUrg high without refReq");

endmodule

// ==== hdl/dtackGen.sv ====
`timescale 1ns/1ps

module dtackGen #(
	parameter int ROM_WAIT = 2
) (
	input logic CLK,
	input logic rstN,
	cpuBusIf.dtack bus,
	input logic busActive,
	input logic ramSel,
	input logic romSel,
	input logic ramReady,
	output logic nDtack,
	output logic romAccess
);
	import memSysPkg::*;

	localparam int WAIT_W = $clog2(ROM_WAIT + 2);

	regionT region;
	logic [WAIT_W-1:0] waitCnt;
	logic ack;

	always_comb begin
		if (ramSel)
			region = REGION_RAM;
		else if (romSel)
			region = REGION_ROM;
		else
			region = REGION_NONE;
	end

	always_comb begin
		ack = 1'b0;
		if (busActive && nDtack && !bus.nAs) begin
			case (region)
				REGION_RAM: ack = ramReady; // Controller not busy refreshing
				REGION_ROM: ack = (waitCnt == WAIT_W'(ROM_WAIT));
				default: ack = 1'b0;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			nDtack <= 1'b1;
			waitCnt <= '0;
			romAccess <= 1'b0;
		end else begin
			romAccess <= ack && (region == REGION_ROM);
			if (bus.nAs) begin // Release on the edge after AS rises
				nDtack <= 1'b1;
				waitCnt <= '0;
			end else if (ack) begin
				nDtack <= 1'b0;
			end else if (busActive && nDtack && region == REGION_ROM) begin
				waitCnt <= waitCnt + 1'b1;
			end
		end
	end

	// A ROM DTACK never comes before its wait states have passed
	romWaitMet: assert property (@(posedge CLK) disable iff (!rstN)
		($fell(nDtack) && romSel) |-> $past(busActive, ROM_WAIT + 1))
		else $error("ROM DTACK before the wait states elapsed");

endmodule

// ==== ram/ramControl.sv ====
`timescale 1ns/1ps

module ramControl (
	input logic CLK,
	input logic rstN,
	cpuBusIf.ram bus,
	input logic busActive,
	input logic ramSel,
	input logic romSel,
	input logic lowRegionSel,
	input logic refReq,
	input logic refUrg,
	output logic refAck,
	output logic ramReady,
	output logic [11:0] ramAddr,
	output logic nRas,
	output logic nCas,
	output logic nLwe,
	output logic nUwe,
	output logic nOe,
	output logic nRomCs,
	output logic nRomWe
);
	import memSysPkg::*;

	ramStateT state;
	logic rasEn; // Idle and allowed to open a row
	logic rasSel; // Column address on the pins
	logic rasRr;
	logic rasRf; // Half-cycle RAS extension after an access
	logic dtackR;
	logic refStart;
	logic accessRas;
	logic [21:1] a;
	logic [11:0] rowAddr;
	logic [11:0] colAddr;

	assign a = bus.address[20:0];

	// Plain requests wait out RAM and low-region cycles, urgent ones do not
	assign refStart = rasEn && (refUrg || (refReq && !(busActive && (ramSel || lowRegionSel))));
	assign accessRas = (state == ST_IDLE) && rasEn && busActive && ramSel && !refStart;

	assign nRas = !(accessRas || rasRr || rasRf);
	assign nLwe = !(!bus.nLds && !bus.nWe && rasSel);
	assign nUwe = !(!bus.nUds && !bus.nWe && rasSel);

	assign nRomCs = !romSel;
	assign nRomWe = !(romSel && !bus.nAs && !bus.nWe);

	assign refAck = (state == ST_REF_RAS1);

	always_comb begin
		if (state == ST_IDLE)
			ramReady = rasEn && !refStart;
		else
			ramReady = (state inside {ST_ACCESS_RAS, ST_ACCESS_HOLD, ST_CYCLE_END});
	end

	assign rowAddr = {a[19], a[17], a[15], a[18], a[14], a[13],
		a[12], a[11], a[19], a[16], a[10], a[9]};
	assign colAddr = {a[20], a[7], a[8], a[21], a[6], a[5],
		a[4], a[3], a[20], a[7], a[2], a[1]};
	assign ramAddr = rasSel ? colAddr : rowAddr;

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			state <= ST_IDLE;
			rasEn <= 1'b0;
			rasSel <= 1'b0;
			rasRr <= 1'b0;
			dtackR <= 1'b0;
			nOe <= 1'b1;
		end else begin
			dtackR <= !bus.nDtack;
			nOe <= bus.nAs || !bus.nWe; // Reads only, follows AS by one edge
			case (state)
				ST_IDLE: begin
					if (refStart) begin
						state <= ST_REF_RAS1; // CAS already low since the falling edge
						rasRr <= 1'b1;
						rasEn <= 1'b0;
					end else if (busActive && ramSel && rasEn) begin
						state <= ST_ACCESS_RAS;
						rasSel <= 1'b1;
						rasRr <= 1'b1;
						rasEn <= 1'b0;
					end else begin
						rasEn <= 1'b1;
					end
				end
				ST_ACCESS_RAS: state <= ST_ACCESS_HOLD;
				ST_ACCESS_HOLD: begin
					if (dtackR) begin
						state <= ST_CYCLE_END;
						rasSel <= 1'b0;
						rasRr <= 1'b0;
					end
				end
				ST_CYCLE_END: begin
					if (!busActive) begin // Wait for AS so one cycle is one access
						state <= ST_IDLE;
						rasEn <= 1'b1;
					end
				end
				ST_REF_RAS1: state <= ST_REF_RAS2;
				ST_REF_RAS2: state <= ST_PRECHARGE;
				ST_PRECHARGE: begin
					if (rasRr)
						rasRr <= 1'b0; // Third RAS cycle, then precharge
					else
						state <= ST_REENABLE;
				end
				ST_REENABLE: begin
					state <= ST_IDLE;
					rasEn <= 1'b1;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(negedge CLK) begin
		if (!rstN) begin
			nCas <= 1'b1;
			rasRf <= 1'b0;
		end else begin
			rasRf <= (state == ST_ACCESS_HOLD);
			case (state)
				ST_IDLE: nCas <= !refStart; // CBR, CAS half a cycle ahead of RAS
				ST_ACCESS_RAS: nCas <= 1'b0;
				ST_ACCESS_HOLD: nCas <= dtackR;
				default: nCas <= 1'b1;
			endcase
		end
	end

	casOnlyInAccess: assert property (@(posedge CLK) disable iff (!rstN)
		($fell(nCas) && !nRas) |-> (state == ST_ACCESS_RAS))
		else $error("nCas fell under an open row outside an access");

	writeUnderRas: assert property (@(posedge CLK) disable iff (!rstN)
		(!nLwe || !nUwe) |-> !nRas)
		else $error("Write strobe low while nRas high");

endmodule

// ==== hdl/memSubsystem.sv ====
`timescale 1ns/1ps

module memSubsystem #(
	parameter int REFRESH_PERIOD = 120,
	parameter int URGENT_DELAY = 40,
	parameter int ROM_WAIT = 2
) (
	input logic CLK,
	input logic rstN,
	input logic [22:0] address,
	input logic nAs,
	input logic nWe,
	input logic nLds,
	input logic nUds,
	output logic nDtack,
	output logic [11:0] ramAddr,
	output logic nRas,
	output logic nCas,
	output logic nLwe,
	output logic nUwe,
	output logic nOe,
	output logic nRomCs,
	output logic nRomWe
);

	logic busActive;
	logic ramSel;
	logic romSel;
	logic lowRegionSel;
	logic romAccess;
	logic refReq;
	logic refUrg;
	logic refAck;
	logic ramReady;

	cpuBusIf bus ();

	assign bus.address = address;
	assign bus.nAs = nAs;
	assign bus.nWe = nWe;
	assign bus.nLds = nLds;
	assign bus.nUds = nUds;
	assign bus.nDtack = nDtack; // Fed back for the controller's DTACK register

	addrDecode u_addrDecode (
		.CLK(CLK), .rstN(rstN), .bus(bus.decode), .romAccess(romAccess),
		.busActive(busActive), .ramSel(ramSel), .romSel(romSel), .lowRegionSel(lowRegionSel)
	);

	refreshTimer #(.REFRESH_PERIOD(REFRESH_PERIOD), .URGENT_DELAY(URGENT_DELAY)) u_refreshTimer (
		.CLK(CLK), .rstN(rstN), .refAck(refAck), .refReq(refReq), .refUrg(refUrg)
	);

	dtackGen #(.ROM_WAIT(ROM_WAIT)) u_dtackGen (
		.CLK(CLK), .rstN(rstN), .bus(bus.dtack), .busActive(busActive), .ramSel(ramSel),
		.romSel(romSel), .ramReady(ramReady), .nDtack(nDtack), .romAccess(romAccess)
	);

	ramControl u_ramControl (
		.CLK(CLK), .rstN(rstN), .bus(bus.ram), .busActive(busActive), .ramSel(ramSel),
		.romSel(romSel), .lowRegionSel(lowRegionSel), .refReq(refReq), .refUrg(refUrg),
		.refAck(refAck), .ramReady(ramReady), .ramAddr(ramAddr), .nRas(nRas), .nCas(nCas),
		.nLwe(nLwe), .nUwe(nUwe), .nOe(nOe), .nRomCs(nRomCs), .nRomWe(nRomWe)
	);

endmodule

// ==== test/tbClock.sv ====
`timescale 1ns/1ps

module tbClock #(
	parameter int HALF_PERIOD = 5,
	parameter int RESET_CYCLES = 4
) (
	output logic CLK,
	output logic rstN
);

	initial begin
		CLK = 1'b0;
		forever #HALF_PERIOD CLK = ~CLK; // 10 ns period
	end

	initial begin
		rstN = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		@(negedge CLK);
		rstN = 1'b1; // Released on a falling edge like the other inputs
	end

endmodule

// ==== test/memSubsystemTb.sv ====
`timescale 1ns/1ps

module memSubsystemTb;

	localparam int REFRESH_PERIOD = 60;
	localparam int URGENT_DELAY = 40;
	localparam int ROM_WAIT = 2;
	localparam int CYCLE_LIMIT = 40; // Clocks allowed for any one wait

	logic CLK;
	logic rstN;
	logic [22:0] address;
	logic nAs, nWe, nLds, nUds;
	logic nDtack;
	logic [11:0] ramAddr;
	logic nRas, nCas, nLwe, nUwe, nOe, nRomCs, nRomWe;

	integer seed = 32'h0d56_51fc;
	int errorCount = 0;
	int checkCount = 0;
	int testCount = 0;
	int testStartErrors = 0;

	// Pin activity since the last clearActivity
	int rasFalls, rasRises, rasLowHalves, lastRasLow, casUnderRas, cbrFalls;
	int lweLow, uweLow, strobeNoRas, oeLow, romCsLow, romWeLow;
	int cbrTotal = 0; // Never cleared
	logic [11:0] rowSeen, colSeen;
	bit prevRas = 1'b1;
	bit prevCas = 1'b1;

	tbClock u_tbClock (.CLK(CLK), .rstN(rstN));

	memSubsystem #(
		.REFRESH_PERIOD(REFRESH_PERIOD),
		.URGENT_DELAY(URGENT_DELAY),
		.ROM_WAIT(ROM_WAIT)
	) u_memSubsystem (
		.CLK(CLK), .rstN(rstN), .address(address), .nAs(nAs), .nWe(nWe), .nLds(nLds),
		.nUds(nUds), .nDtack(nDtack), .ramAddr(ramAddr), .nRas(nRas), .nCas(nCas),
		.nLwe(nLwe), .nUwe(nUwe), .nOe(nOe), .nRomCs(nRomCs), .nRomWe(nRomWe)
	);

	// Samples the memory pins 1 ns after every clock edge
	always @(CLK) begin
		#1;
		if (!nRas && prevRas) begin
			rasFalls++;
			rowSeen = ramAddr;
		end
		if (nRas && !prevRas) begin
			rasRises++;
			lastRasLow = rasLowHalves;
		end
		rasLowHalves = nRas ? 0 : rasLowHalves + 1;
		if (!nCas && prevCas) begin
			if (nRas) begin // CAS before RAS means refresh
				cbrFalls++;
				cbrTotal++;
			end else begin
				casUnderRas++;
				colSeen = ramAddr;
			end
		end
		if (!nLwe)
			lweLow++;
		if (!nUwe)
			uweLow++;
		if ((!nLwe || !nUwe) && nRas)
			strobeNoRas++;
		if (!nOe)
			oeLow++;
		if (!nRomCs)
			romCsLow++;
		if (!nRomWe)
			romWeLow++;
		prevRas = nRas;
		prevCas = nCas;
	end

	// DRAM pin map, pin 0 upward, as documented in memSysPkg
	function automatic logic [11:0] pinMap(input logic [23:0] byteAddr, input bit column);
		int rowBit [12];
		int colBit [12];
		int p;
		logic [11:0] pins;
		rowBit = '{9, 10, 16, 19, 11, 12, 13, 14, 18, 15, 17, 19};
		colBit = '{1, 2, 7, 20, 3, 4, 5, 6, 21, 8, 7, 20};
		for (p = 0; p < 12; p++)
			pins[p] = byteAddr[column ? colBit[p] : rowBit[p]];
		return pins;
	endfunction

	task automatic checkEq(input string name, input int got, input int expected);
		checkCount++;
		if (got != expected) begin
			errorCount++;
			$display("** Error at %0t: %s = %0h, expected %0h", $time, name, got, expected);
		end
	endtask

	task automatic clearActivity();
		rasFalls = 0;
		rasRises = 0;
		casUnderRas = 0;
		cbrFalls = 0;
		lweLow = 0;
		uweLow = 0;
		strobeNoRas = 0;
		oeLow = 0;
		romCsLow = 0;
		romWeLow = 0;
	endtask

	// One CPU bus cycle, dtackEdges counts clocks from nAs low to nDtack seen, -1 on timeout
	task automatic busCycle(input logic [23:0] byteAddr, input bit write, input bit lower,
			input bit upper, output int dtackEdges);
		int n;
		@(negedge CLK);
		address = byteAddr[23:1];
		nWe = !write;
		nLds = !lower;
		nUds = !upper;
		nAs = 1'b0;
		clearActivity();
		n = 0;
		do begin
			@(negedge CLK);
			n++;
		end while (nDtack && n < CYCLE_LIMIT);
		if (nDtack) begin
			errorCount++;
			dtackEdges = -1;
			$display("Timeout at %0t: no DTACK for the cycle at %h", $time, byteAddr);
		end else begin
			dtackEdges = n;
		end
		@(negedge CLK); // CPU finishes the cycle
		nAs = 1'b1;
		nLds = 1'b1;
		nUds = 1'b1;
		nWe = 1'b1;
		@(negedge CLK);
		checkEq("nDtack after nAs rose", int'(nDtack), 1);
		checkEq("nOe after nAs rose", int'(nOe), 1);
	endtask

	task automatic endTest(input string name);
		testCount++;
		$display("%s: done at %0t, %0d failed checks", name, $time,
			errorCount - testStartErrors);
		testStartErrors = errorCount;
	endtask

	task automatic bootOverlay();
		int edges;
		busCycle(24'h000000, 1'b0, 1'b1, 1'b1, edges); // Boot vector fetch
		checkEq("nRomCs low at zero", int'(romCsLow > 0), 1);
		checkEq("nRas falls at zero", rasFalls, 0);
		busCycle(24'h400010, 1'b0, 1'b1, 1'b1, edges);
		busCycle(24'h000000, 1'b0, 1'b1, 1'b1, edges);
		checkEq("nRas falls at zero", int'(rasFalls > 0), 1);
		checkEq("nRomCs low at zero", romCsLow, 0);
		endTest("boot overlay");
	endtask

	task automatic ramReads();
		logic [23:0] byteAddr;
		int edges;
		repeat (6) begin
			byteAddr = 24'($random(seed)) & 24'h3FFFFE;
			busCycle(byteAddr, 1'b0, 1'b1, 1'b1, edges);
			checkEq("ramAddr row", int'(rowSeen), int'(pinMap(byteAddr, 1'b0)));
			checkEq("ramAddr column", int'(colSeen), int'(pinMap(byteAddr, 1'b1)));
			checkEq("nOe low", int'(oeLow > 0), 1);
		end
		endTest("RAM read");
	endtask

	task automatic byteWrites();
		int lane;
		int edges;
		for (lane = 1; lane <= 3; lane++) begin // Lower, upper, word
			busCycle(24'h012340, 1'b1, lane[0], lane[1], edges);
			checkEq("nLwe low", int'(lweLow > 0), int'(lane[0]));
			checkEq("nUwe low", int'(uweLow > 0), int'(lane[1]));
			checkEq("write strobe with nRas high", strobeNoRas, 0);
			checkEq("nRomWe low on RAM write", romWeLow, 0);
		end
		endTest("RAM byte writes");
	endtask

	task automatic romCycles();
		int edges;
		busCycle(24'h400100, 1'b0, 1'b1, 1'b1, edges);
		checkEq("clocks busActive to nDtack", edges - 1, ROM_WAIT + 1);
		checkEq("nRomCs low", int'(romCsLow > 0), 1);
		checkEq("nRomWe low on ROM read", romWeLow, 0);
		checkEq("nRomCs after cycle", int'(nRomCs), 1);
		busCycle(24'h400100, 1'b1, 1'b1, 1'b1, edges); // Flash write strobe
		checkEq("nRomWe low on ROM write", int'(romWeLow > 0), 1);
		checkEq("nRomWe after cycle", int'(nRomWe), 1);
		endTest("ROM cycles");
	endtask

	task automatic idleRefresh();
		int n;
		int rises;
		clearActivity();
		n = 0;
		while (cbrFalls == 0 && n < REFRESH_PERIOD + 8) begin
			@(negedge CLK);
			n++;
		end
		if (cbrFalls == 0) begin
			errorCount++;
			$display("Timeout at %0t: no CAS-before-RAS refresh with the bus idle", $time);
		end else begin
			rises = rasRises;
			n = 0;
			while (rasRises == rises && n < 10) begin
				@(negedge CLK);
				n++;
			end
			if (rasRises == rises) begin
				errorCount++;
				$display("Timeout at %0t: nRas did not rise after the refresh", $time);
			end else begin
				checkEq("nRas low half-cycles in refresh", lastRasLow, 6); // Three clocks
			end
		end
		endTest("idle refresh");
	endtask

	task automatic loadRefresh();
		logic [23:0] byteAddr;
		int startCbr;
		int i;
		int edges;
		startCbr = cbrTotal;
		for (i = 0; i < 24; i++) begin // Spans two refresh periods
			byteAddr = 24'($random(seed)) & 24'h3FFFFE;
			busCycle(byteAddr, i[0], 1'b1, 1'b1, edges);
			checkEq("cycle completed", int'(edges > 0), 1);
			checkEq("CAS falls under RAS", casUnderRas, 1);
			checkEq("ramAddr column", int'(colSeen), int'(pinMap(byteAddr, 1'b1)));
			checkEq("write strobe with nRas high", strobeNoRas, 0);
		end
		checkEq("refreshes during load", int'(cbrTotal > startCbr), 1);
		endTest("refresh under load");
	endtask

	initial begin
		int n;
		address = '0;
		nAs = 1'b1;
		nWe = 1'b1;
		nLds = 1'b1;
		nUds = 1'b1;
		clearActivity();
		n = 0;
		do begin
			@(posedge CLK);
			n++;
		end while (!rstN && n < 20);
		bootOverlay();
		ramReads();
		byteWrites();
		romCycles();
		idleRefresh();
		loadRefresh();
		$display("Summary: %0d tests, %0d checks, %0d failed", testCount, checkCount,
			errorCount);
		if (errorCount == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// ==== memSubsystem.f ====
common/memSysPkg.sv
common/cpuBusIf.sv
hdl/addrDecode.sv
hdl/refreshTimer.sv
hdl/dtackGen.sv
ram/ramControl.sv
hdl/memSubsystem.sv
test/tbClock.sv
test/memSubsystemTb.sv

// ==== Makefile ====
LOG = sim.log

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run memSubsystemTb, fail on reported errors"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -f memSubsystem.f \
		--top-module memSubsystemTb -Mdir obj_dir -o simv
	./obj_dir/simv | tee $(LOG)
	@if grep -q "Errors found" $(LOG) || ! grep -q "No errors" $(LOG); then \
		echo "FAIL"; exit 1; else echo "PASS"; fi

clean:
	rm -rf obj_dir $(LOG)

.PHONY: help test clean
